// File: common/queue_macros.svh
/*
  Delay skid queue configuration: item width, queue depth and hold time
*/
`ifndef QUEUE_MACROS_SVH
`define QUEUE_MACROS_SVH

// Width of one item in bits
`define DSQ_DATA_W   8

// Skid queue depth and matching pointer width
`define DSQ_ENTRIES  4
`define DSQ_PTR_W    2

// Fixed hold time in cycles, from 1 up to 255
`define DSQ_DELAY    3

// Delay counter width, wide enough for DSQ_DELAY
`define DSQ_TIMER_W  8

`endif

// File: common/queue_pkg.sv
/*
  Queue types shared by the skid queue, the bypass slot and the top level
*/
`include "queue_macros.svh"

package queue_pkg;

  // ----------------------------------------
  // Payload and addressing
  // ----------------------------------------

  // One queued item
  typedef logic [`DSQ_DATA_W-1:0] data_t;

  // Register file address, also the enqueue and dequeue pointers
  typedef logic [`DSQ_PTR_W-1:0] ptr_t;

  // Free-entry count, one bit wider so that a full count fits
  typedef logic [`DSQ_PTR_W:0] count_t;

endpackage

// File: common/delay_pkg.sv
/*
  Delay timer types: the hold count and the timer state
*/
`include "queue_macros.svh"

package delay_pkg;

  // Remaining hold cycles of the head item
  typedef logic [`DSQ_TIMER_W-1:0] timer_t;

  // Idle until a head item shows up, then hold it
  typedef enum logic {
    DELAY_IDLE,
    DELAY_HOLD
  } delay_state_t;

endpackage

// File: skid_queue/skid_queue_ctrl.sv
/*
  Skid queue control: wrapping pointers, full flag, handshakes and the
  free-entry count used by upstream logic to stall early
*/
`timescale 1ns/10ps
`include "queue_macros.svh"

module skid_queue_ctrl (
  input  logic              clk,
  input  logic              reset,
  input  logic              enq_val,
  output logic              enq_rdy,
  output logic              head_val,
  input  logic              head_rdy,
  output logic              wen,
  output queue_pkg::ptr_t   waddr,
  output queue_pkg::ptr_t   raddr,
  output queue_pkg::count_t num_free_entries
);

  import queue_pkg::*;

  // ----------------------------------------
  // State
  // ----------------------------------------

  ptr_t   enq_ptr;
  ptr_t   deq_ptr;
  // Set when the pointers meet with every entry in use
  logic   full;
  logic   empty;
  logic   do_enq;
  logic   do_deq;
  ptr_t   enq_ptr_inc;
  ptr_t   deq_ptr_inc;
  // Occupancy tracked on its own, only to cross-check the pointers
  count_t occupancy;

  // Transfers on both sides
  assign do_enq = enq_val && enq_rdy;
  assign do_deq = head_val && head_rdy;

  assign empty    = !full && (enq_ptr == deq_ptr);
  assign enq_rdy  = !full;
  assign head_val = !empty;

  // Every accepted item goes into storage
  assign wen   = do_enq;
  assign waddr = enq_ptr;
  assign raddr = deq_ptr;

  // Next pointer values, wrapping at the depth
  assign enq_ptr_inc = (count_t'(enq_ptr) + 1'b1 == count_t'(`DSQ_ENTRIES))
                       ? '0 : enq_ptr + 1'b1;
  assign deq_ptr_inc = (count_t'(deq_ptr) + 1'b1 == count_t'(`DSQ_ENTRIES))
                       ? '0 : deq_ptr + 1'b1;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      enq_ptr <= '0;
      deq_ptr <= '0;
      full    <= 1'b0;
    end
    else
    begin
      if (do_enq)
        enq_ptr <= enq_ptr_inc;
      if (do_deq)
        deq_ptr <= deq_ptr_inc;
      // Full only when an enqueue catches up with the dequeue pointer
      if (do_enq && !do_deq && (enq_ptr_inc == deq_ptr))
        full <= 1'b1;
      else if (do_deq && !do_enq)
        full <= 1'b0;
    end
  end

  // ----------------------------------------
  // Free entries
  // ----------------------------------------

  always_comb
  begin
    if (full)
      num_free_entries = '0;
    else if (empty)
      num_free_entries = count_t'(`DSQ_ENTRIES);
    else if (enq_ptr > deq_ptr)
      num_free_entries = count_t'(`DSQ_ENTRIES) - count_t'(enq_ptr - deq_ptr);
    else
      num_free_entries = count_t'(deq_ptr - enq_ptr);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      occupancy <= '0;
    else if (do_enq && !do_deq)
      occupancy <= occupancy + 1'b1;
    else if (do_deq && !do_enq)
      occupancy <= occupancy - 1'b1;
  end

  // Queue never holds more than its depth
  assert property (@(posedge clk) disable iff (reset)
    occupancy <= count_t'(`DSQ_ENTRIES));

  // Pointer-derived count agrees with the transfer history
  assert property (@(posedge clk) disable iff (reset)
    occupancy + num_free_entries == count_t'(`DSQ_ENTRIES));

endmodule

// File: skid_queue/skid_queue_store.sv
/*
  Skid queue storage: one write port on the clock edge, one
  combinational read port
*/
`timescale 1ns/10ps
`include "queue_macros.svh"

module skid_queue_store (
  input  logic             clk,
  input  logic             wen,
  input  queue_pkg::ptr_t  waddr,
  input  queue_pkg::ptr_t  raddr,
  input  queue_pkg::data_t wdata,
  output queue_pkg::data_t rdata
);

  import queue_pkg::*;

  // One row per queue entry
  data_t mem [`DSQ_ENTRIES];

  // ----------------------------------------
  // Write port
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (wen)
      mem[waddr] <= wdata;
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------

  // Head item seen by the timer without a cycle of latency
  assign rdata = mem[raddr];

endmodule

// File: source/delay_timer.sv
/*
  Delay timer: holds the skid queue head for a fixed number of cycles,
  then hands it to the bypass slot
*/
`timescale 1ns/10ps
`include "queue_macros.svh"

module delay_timer (
  input  logic clk,
  input  logic reset,
  input  logic head_val,
  output logic head_rdy,
  output logic slot_enq_val,
  input  logic slot_enq_rdy
);

  import delay_pkg::*;

  delay_state_t state;
  timer_t       count;
  // Last hold cycle with room downstream
  logic         release_now;

  assign release_now = (state == DELAY_HOLD) && (count == timer_t'(1)) && slot_enq_rdy;

  // Pop the queue and offer to the slot in the same cycle
  assign head_rdy     = release_now;
  assign slot_enq_val = release_now;

  // ----------------------------------------
  // FSM and down-counter
  // ----------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= DELAY_IDLE;
      count <= '0;
    end
    else
    begin
      case (state)
        DELAY_IDLE:
        begin
          // Start the hold as soon as an item reaches the head
          if (head_val)
          begin
            count <= timer_t'(`DSQ_DELAY);
            state <= DELAY_HOLD;
          end
        end
        DELAY_HOLD:
        begin
          // Frozen while the slot is full
          if (slot_enq_rdy)
          begin
            count <= count - 1'b1;
            if (count == timer_t'(1))
              state <= DELAY_IDLE;
          end
        end
        default:
        begin
          state <= DELAY_IDLE;
        end
      endcase
    end
  end

  // Count stays within the configured hold time
  assert property (@(posedge clk) disable iff (reset)
    count <= timer_t'(`DSQ_DELAY));

  // Head item cannot vanish from the queue during a hold
  assert property (@(posedge clk) disable iff (reset)
    (state == DELAY_HOLD) |-> head_val);

endmodule

// File: source/bypass_slot.sv
/*
  One-element bypass queue in front of the consumer
*/
`timescale 1ns/10ps

module bypass_slot (
  input  logic             clk,
  input  logic             reset,
  input  logic             enq_val,
  output logic             enq_rdy,
  input  queue_pkg::data_t enq_bits,
  output logic             deq_val,
  input  logic             deq_rdy,
  output queue_pkg::data_t deq_bits
);

  import queue_pkg::*;

  logic  full;
  data_t slot_data;
  logic  do_enq;
  logic  do_deq;
  logic  wen;

  assign enq_rdy = !full;
  assign do_enq  = enq_val && enq_rdy;
  assign do_deq  = deq_val && deq_rdy;

  // ----------------------------------------
  // Bypass path
  // ----------------------------------------

  // Empty slot shows the offered item in the same cycle
  assign deq_val  = full || enq_val;
  assign deq_bits = full ? slot_data : enq_bits;

  // Store only what the consumer did not take right away
  assign wen = do_enq && !do_deq;

  always_ff @(posedge clk)
  begin
    if (reset)
      full <= 1'b0;
    else if (wen)
      full <= 1'b1;
    else if (do_deq)
      full <= 1'b0;
  end

  // Payload register
  always_ff @(posedge clk)
  begin
    if (wen)
      slot_data <= enq_bits;
  end

  // No item offered for writing while the slot still holds one
  assert property (@(posedge clk) disable iff (reset)
    enq_val |-> !full);

  // A stalled item stays put until the consumer takes it
  assert property (@(posedge clk) disable iff (reset)
    (deq_val && !deq_rdy) |=> (deq_val && $stable(deq_bits)));

endmodule

// File: source/delay_skid_queue.sv
/*
  Delay skid queue top: skid queue, fixed delay timer and a bypass slot
  toward the consumer
*/
`timescale 1ns/10ps

module delay_skid_queue (
  input  logic              clk,
  input  logic              reset,
  input  logic              enq_val,
  output logic              enq_rdy,
  input  queue_pkg::data_t  enq_bits,
  output logic              deq_val,
  input  logic              deq_rdy,
  output queue_pkg::data_t  deq_bits,
  output queue_pkg::count_t num_free_entries
);

  import queue_pkg::*;

  // Skid queue internals
  logic  wen;
  ptr_t  waddr;
  ptr_t  raddr;

  // Head of queue toward the timer
  logic  head_val;
  logic  head_rdy;
  data_t head_bits;

  // Timer toward the slot
  logic  slot_enq_val;
  logic  slot_enq_rdy;

  // ----------------------------------------
  // Skid queue
  // ----------------------------------------

  skid_queue_ctrl u_skid_queue_ctrl (
    .clk              (clk),
    .reset            (reset),
    .enq_val          (enq_val),
    .enq_rdy          (enq_rdy),
    .head_val         (head_val),
    .head_rdy         (head_rdy),
    .wen              (wen),
    .waddr            (waddr),
    .raddr            (raddr),
    .num_free_entries (num_free_entries)
  );

  skid_queue_store u_skid_queue_store (
    .clk   (clk),
    .wen   (wen),
    .waddr (waddr),
    .raddr (raddr),
    .wdata (enq_bits),
    .rdata (head_bits)
  );

  // ----------------------------------------
  // Delay and output stage
  // ----------------------------------------

  delay_timer u_delay_timer (
    .clk          (clk),
    .reset        (reset),
    .head_val     (head_val),
    .head_rdy     (head_rdy),
    .slot_enq_val (slot_enq_val),
    .slot_enq_rdy (slot_enq_rdy)
  );

  // Head data goes straight to the slot, the timer only gates it
  bypass_slot u_bypass_slot (
    .clk      (clk),
    .reset    (reset),
    .enq_val  (slot_enq_val),
    .enq_rdy  (slot_enq_rdy),
    .enq_bits (head_bits),
    .deq_val  (deq_val),
    .deq_rdy  (deq_rdy),
    .deq_bits (deq_bits)
  );

endmodule

// File: verif/tb_delay_skid_queue.sv
/*
  Delay skid queue testbench: reset state, release timing, back-pressure
  fill and random traffic checked against an in-order reference model
*/
`timescale 1ns/10ps
`include "queue_macros.svh"

module tb_delay_skid_queue;

  import queue_pkg::*;
  import delay_pkg::*;

  // ----------------------------------------
  // Run length and timing
  // ----------------------------------------

  localparam int PERIOD        = 40;
  localparam int NUM_RANDOM    = 200;
  // One item leaves per hold plus one handoff cycle
  localparam int ITEM_CYCLES   = `DSQ_DELAY + 1;
  localparam int OFFER_LIMIT   = 4 * ITEM_CYCLES;
  localparam int SETTLE_CYCLES = 2 * ITEM_CYCLES;
  localparam int DRAIN_LIMIT   = 2 * (`DSQ_ENTRIES + 2) * ITEM_CYCLES;
  localparam int TOTAL_ITEMS   = NUM_RANDOM + 2 * `DSQ_ENTRIES + 3;
  // Three times the ideal rate covers random stalls, plus fixed slack
  localparam int WATCHDOG_CYCLES = 3 * TOTAL_ITEMS * ITEM_CYCLES + 1000;

  logic   clk;
  logic   reset;
  logic   enq_val;
  logic   enq_rdy;
  data_t  enq_bits;
  logic   deq_val;
  logic   deq_rdy;
  data_t  deq_bits;
  count_t num_free_entries;

  integer seed;

  // Reference model and transfer history
  data_t model_q[$];
  int    enq_edges[$];
  int    deq_edges[$];
  int    edge_cnt;
  int    enq_count;
  int    deq_count;
  logic  enq_fire;

  delay_skid_queue u_delay_skid_queue (
    .clk              (clk),
    .reset            (reset),
    .enq_val          (enq_val),
    .enq_rdy          (enq_rdy),
    .enq_bits         (enq_bits),
    .deq_val          (deq_val),
    .deq_rdy          (deq_rdy),
    .deq_bits         (deq_bits),
    .num_free_entries (num_free_entries)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------

  task automatic stop_with_failure();
    $display("=== FAIL ===");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t: %s got 0x%02h, expected 0x%02h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t: %s got %0d, expected %0d", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR at %0t: %s got %b, expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_int(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("ERROR at %0t: %s got %0d, expected %0d", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  // ----------------------------------------
  // Monitor, sampled on the rising edge
  // ----------------------------------------

  always @(posedge clk)
  begin
    data_t expected;
    edge_cnt++;
    enq_fire = enq_val && enq_rdy;
    if (!reset)
    begin
      // Ready must track the free count
      check_flag("enq_rdy", enq_rdy, num_free_entries != count_t'(0));
      if (num_free_entries > count_t'(`DSQ_ENTRIES))
      begin
        $display("Free-entry count %0d is above the queue depth", num_free_entries);
        stop_with_failure();
      end
      if (deq_val && deq_rdy)
      begin
        if (model_q.size() == 0)
        begin
          $display("DUT delivered an item at %0t that was never accepted", $time);
          stop_with_failure();
        end
        expected = model_q.pop_front();
        check_data("deq_bits", deq_bits, expected);
        deq_count++;
        deq_edges.push_back(edge_cnt);
      end
      if (enq_fire)
      begin
        model_q.push_back(enq_bits);
        enq_count++;
        enq_edges.push_back(edge_cnt);
      end
    end
  end

  // ----------------------------------------
  // Stimulus helpers, called on a falling edge
  // ----------------------------------------

  // Offer n items, keeping the last one pending if the limit runs out
  task automatic offer_items(input int n, input int max_cycles, output int accepted);
    int start;
    int cycles;
    start  = enq_count;
    cycles = 0;
    while ((enq_count - start < n) && (cycles < max_cycles))
    begin
      if (!enq_val || enq_fire)
        enq_bits = data_t'($random(seed));
      enq_val = 1'b1;
      @(negedge clk);
      cycles++;
    end
    if (enq_count - start >= n)
      enq_val = 1'b0;
    accepted = enq_count - start;
  endtask

  task automatic wait_for_drain(input int max_cycles);
    int cycles;
    cycles = 0;
    while ((model_q.size() != 0) && (cycles < max_cycles))
    begin
      @(negedge clk);
      cycles++;
    end
    if (model_q.size() != 0)
    begin
      $display("Timed out with %0d items still inside the DUT", model_q.size());
      stop_with_failure();
    end
  endtask

  // Items leave one hold period apart, first one a hold after acceptance
  task automatic check_release_times(input int n);
    int i;
    check_int("dequeued items", deq_edges.size(), n);
    for (i = 0; i < n; i++)
      check_int("dequeue edge", deq_edges[i], enq_edges[0] + (i + 1) * ITEM_CYCLES);
  endtask

  task automatic run_random_traffic(input int n);
    int start;
    start = enq_count;
    while (enq_count - start < n)
    begin
      if (!enq_val || enq_fire)
      begin
        enq_val  = ($random(seed) & 3) != 0;
        enq_bits = data_t'($random(seed));
      end
      deq_rdy = ($random(seed) & 3) != 0;
      @(negedge clk);
    end
    enq_val = 1'b0;
    deq_rdy = 1'b1;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial
  begin
    int accepted;
    int total;
    int exp_free;
    int k;
    seed      = 53;
    reset     = 1'b1;
    enq_val   = 1'b0;
    enq_bits  = '0;
    deq_rdy   = 1'b0;
    edge_cnt  = 0;
    enq_count = 0;
    deq_count = 0;
    enq_fire  = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Idle state out of reset
    check_flag("deq_val", deq_val, 1'b0);
    check_flag("enq_rdy", enq_rdy, 1'b1);
    check_count("num_free_entries", num_free_entries, count_t'(`DSQ_ENTRIES));

    // Single item, then a burst, with the consumer always ready
    deq_rdy = 1'b1;
    enq_edges.delete();
    deq_edges.delete();
    offer_items(1, OFFER_LIMIT, accepted);
    wait_for_drain(DRAIN_LIMIT);
    check_release_times(1);
    enq_edges.delete();
    deq_edges.delete();
    offer_items(`DSQ_ENTRIES, OFFER_LIMIT, accepted);
    wait_for_drain(DRAIN_LIMIT);
    check_release_times(`DSQ_ENTRIES);

    // Stalled consumer: slot fills first, then the skid queue
    deq_rdy = 1'b0;
    total   = 0;
    for (k = 0; k < `DSQ_ENTRIES + 2; k++)
    begin
      offer_items(1, OFFER_LIMIT, accepted);
      check_int("accepted while stalled", accepted, (total < `DSQ_ENTRIES + 1) ? 1 : 0);
      total += accepted;
      repeat (SETTLE_CYCLES) @(negedge clk);
      exp_free = `DSQ_ENTRIES - (total - 1);
      if (exp_free < 0)
        exp_free = 0;
      check_count("num_free_entries", num_free_entries, count_t'(exp_free));
    end
    check_flag("enq_rdy", enq_rdy, 1'b0);

    // Release the consumer so the pending item gets in
    deq_rdy = 1'b1;
    offer_items(1, DRAIN_LIMIT, accepted);
    check_int("accepted after release", accepted, 1);
    wait_for_drain(DRAIN_LIMIT);

    run_random_traffic(NUM_RANDOM);
    wait_for_drain(DRAIN_LIMIT);
    @(negedge clk);
    check_int("items dequeued", deq_count, TOTAL_ITEMS);
    check_flag("deq_val", deq_val, 1'b0);
    check_count("num_free_entries", num_free_entries, count_t'(`DSQ_ENTRIES));

    $display("=== PASS ===");
    $finish;
  end

  // Watchdog sized from the item count
  initial
  begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("Simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
    stop_with_failure();
  end

endmodule

// File: delay_skid_queue.f
+incdir+common
common/queue_pkg.sv
common/delay_pkg.sv
skid_queue/skid_queue_ctrl.sv
skid_queue/skid_queue_store.sv
source/delay_timer.sv
source/bypass_slot.sv
source/delay_skid_queue.sv
verif/tb_delay_skid_queue.sv

// File: Makefile
# Verilator build and run for the delay skid queue testbench

TOP := tb_delay_skid_queue

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  -f delay_skid_queue.f --top-module $(TOP) \
	  -Mdir obj_dir -o V$(TOP)

# The run passes only if the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
